/* verif/conv_stimulus.txt */
// Job count, then per job: header {kh1 max relu cols1 cin1} one hex digit each,
// records {w2 w1 w0, p5..p0} per column and channel, expected {res3..res0} per column
5
// 3x3 sum, two channels, four column groups
20031
010201050403020100
0100ff050403020100
010201fbfcfdfeff00
0100ff0a0806040200
010201050505050505
0100ff070707070707
010201000032000000
0100fff1f4f7fafd00
000120000e0000a00006
ffff4ffff8ffffc00000
00014000140001400014
0002c0005e0002cffffa
// 1x1 kernel
00011
000003050403020100
0000fe0a0806040200
000003070707070707
0000fefbfcfdfeff00
ffffdffffefffff00000
0001b000190001700015
// Max mode
21001
0100ff050403020100
010201f1f4f7fafd00
00005000040000300002
// Negative sums with ReLU on, then off
20100
ffffff050403020100
00000000000000000000
20000
ffffff050403020100
ffff4ffff7ffffaffffd

/* tb.f */
+incdir+rtl
rtl/conv_cfg_pkg.sv
rtl/conv_stream_pkg.sv
rtl/axis_reg_slice.sv
rtl/axis_shift_buffer.sv
rtl/conv_unit.sv
rtl/axis_conv_engine.sv
verif/conv_engine_asserts.sv
verif/conv_engine_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= conv_engine_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* verif/conv_engine_tb.sv */
////////////////////
// Runs from the project root and reads verif/conv_stimulus.txt
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_engine_tb;

    import conv_cfg_pkg::*;
    import conv_stream_pkg::*;

    localparam int TIMEOUT = 2000;

    logic        aclk;
    logic        aclken;
    logic        rst_n;
    logic        start;
    conv_cfg_t   cfg;
    logic        pixels_s_valid;
    pix_beat_t   pixels_s_data;
    logic        pixels_s_ready;
    logic        weights_s_valid;
    wgt_beat_t   weights_s_data;
    logic        weights_s_ready;
    logic        m_valid;
    out_beat_t   m_data;
    logic        done;

    logic [95:0] stim [0:63];
    logic [47:0] rec_pix [0:31];
    logic [23:0] rec_wgt [0:31];
    logic [79:0] exp_word [0:15];
    int          kh;
    int          is_max;
    int          is_relu;
    int          ncols;
    int          nch;
    int          check_errors;
    int          other_errors;
    int          out_cnt;
    int          done_cnt;
    bit          aborted;

    axis_conv_engine dut0 (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .start(start), .cfg(cfg),
        .pixels_s_valid(pixels_s_valid), .pixels_s_data(pixels_s_data),
        .pixels_s_ready(pixels_s_ready),
        .weights_s_valid(weights_s_valid), .weights_s_data(weights_s_data),
        .weights_s_ready(weights_s_ready),
        .m_valid(m_valid), .m_data(m_data), .done(done)
    );

    bind axis_conv_engine conv_engine_asserts asserts0 (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .start(start),
        .pixels_q_valid(pixels_q_valid), .pixels_q_data(pixels_q_data),
        .pixels_q_ready(pixels_q_ready),
        .weights_q_valid(weights_q_valid), .weights_q_data(weights_q_data),
        .weights_q_ready(weights_q_ready),
        .win_valid(win_valid), .win_data(win_data), .win_ready(win_ready),
        .m_valid(m_valid), .done(done)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Random enable gaps of about one cycle in five
    always @(posedge aclk) begin
        #2;
        if (rst_n) begin
            aclken = ($urandom_range(0, 4) != 0);
        end
    end

    always @(negedge aclk) begin
        if (rst_n && aclken) begin
            if (m_valid) out_cnt++;
            if (done) done_cnt++;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic timed_out(input string what);
        $display("ERROR: timed out waiting for %s", what);
        other_errors++;
        aborted = 1'b1;
    endtask

    // Sum or max over channels and kernel rows and then ReLU
    function automatic int rule_result(int g, int i);
        int                acc;
        int                v;
        int                rec;
        bit                first_v;
        logic signed [7:0] p;
        logic signed [7:0] w;
        acc = 0;
        first_v = 1'b1;
        for (int c = 0; c < nch; c++) begin
            rec = g * nch + c;
            for (int r = 0; r <= kh; r++) begin
                p = rec_pix[rec][8*(i+r) +: 8];
                w = rec_wgt[rec][8*r +: 8];
                v = (is_max != 0) ? int'(p) : int'(p) * int'(w);
                if (first_v) acc = v;
                else if (is_max != 0) acc = (v > acc) ? v : acc;
                else acc = acc + v;
                first_v = 1'b0;
            end
        end
        if (is_relu != 0 && acc < 0) acc = 0;
        return acc;
    endfunction

    task automatic send_start(input conv_cfg_t c);
        int t;
        @(posedge aclk);
        #2;
        start = 1'b1;
        cfg = c;
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge aclk);
            if (aclken) break;
        end
        if (t == TIMEOUT) timed_out("an enabled cycle for start");
        @(posedge aclk);
        #2;
        start = 1'b0;
    endtask

    task automatic drive_pixels();
        int t;
        for (int k = 0; k < ncols * nch && !aborted; k++) begin
            repeat ($urandom_range(0, 2)) begin
                @(posedge aclk);
                #2;
            end
            pixels_s_valid = 1'b1;
            pixels_s_data = rec_pix[k];
            for (t = 0; t < TIMEOUT; t++) begin
                @(negedge aclk);
                if (pixels_s_ready && aclken) break;
            end
            if (t == TIMEOUT) timed_out("pixels_s_ready");
            @(posedge aclk);
            #2;
            pixels_s_valid = 1'b0;
        end
    endtask

    // Same weight beat once per kernel row
    task automatic drive_weights();
        int t;
        for (int k = 0; k < ncols * nch * (kh + 1) && !aborted; k++) begin
            repeat ($urandom_range(0, 2)) begin
                @(posedge aclk);
                #2;
            end
            weights_s_valid = 1'b1;
            weights_s_data = rec_wgt[k / (kh + 1)];
            for (t = 0; t < TIMEOUT; t++) begin
                @(negedge aclk);
                if (weights_s_ready && aclken) break;
            end
            if (t == TIMEOUT) timed_out("weights_s_ready");
            @(posedge aclk);
            #2;
            weights_s_valid = 1'b0;
        end
    endtask

    task automatic collect_outputs(input int j);
        int t;
        for (int g = 0; g < ncols && !aborted; g++) begin
            for (t = 0; t < TIMEOUT; t++) begin
                @(negedge aclk);
                if (m_valid && aclken) break;
            end
            if (t == TIMEOUT) begin
                timed_out("an output beat");
                return;
            end
            for (int i = 0; i < `CONV_UNITS; i++) begin
                check($sformatf("job%0d col%0d unit%0d", j, g, i),
                      {12'd0, exp_word[g][20*i +: 20]}, {12'd0, m_data.res[i]});
            end
            check($sformatf("job%0d col%0d last", j, g),
                  (g == ncols - 1) ? 32'd1 : 32'd0, {31'd0, m_data.last});
        end
        for (t = 0; t < TIMEOUT && !aborted; t++) begin
            @(negedge aclk);
            if (done && aclken) break;
        end
        if (t == TIMEOUT) timed_out("done");
    endtask

    task automatic run_job(input int j, inout int ptr);
        logic [19:0] hdr;
        conv_cfg_t   c;
        conv_cfg_t   stray;
        int          outs0;
        int          dones0;
        hdr = stim[ptr][19:0];
        ptr++;
        kh = int'(hdr[19:16]);
        is_max = int'(hdr[15:12]);
        is_relu = int'(hdr[11:8]);
        ncols = int'(hdr[7:4]) + 1;
        nch = int'(hdr[3:0]) + 1;
        for (int k = 0; k < ncols * nch; k++) begin
            rec_pix[k] = stim[ptr][47:0];
            rec_wgt[k] = stim[ptr][71:48];
            ptr++;
        end
        for (int g = 0; g < ncols; g++) begin
            exp_word[g] = stim[ptr][79:0];
            ptr++;
            for (int i = 0; i < `CONV_UNITS; i++) begin
                check($sformatf("job%0d stimulus col%0d unit%0d", j, g, i),
                      {12'd0, exp_word[g][20*i +: 20]}, 32'(rule_result(g, i)) & 32'hfffff);
            end
        end
        c.kernel_h_1 = hdr[17:16];
        c.is_max = hdr[12];
        c.is_relu = hdr[8];
        c.cols_1 = hdr[7:4];
        c.cin_1 = hdr[3:0];
        // Flipped mode that must be ignored mid job
        stray = c;
        stray.is_max = !c.is_max;
        stray.is_relu = !c.is_relu;
        outs0 = out_cnt;
        dones0 = done_cnt;
        send_start(c);
        fork
            drive_pixels();
            drive_weights();
            collect_outputs(j);
            if (j == 0) begin
                repeat (8) @(posedge aclk);
                send_start(stray);
            end
        join
        repeat (20) @(negedge aclk);
        check($sformatf("job%0d output count", j), 32'(ncols), 32'(out_cnt - outs0));
        check($sformatf("job%0d done count", j), 32'd1, 32'(done_cnt - dones0));
    endtask

    initial begin
        int njobs;
        int ptr;
        void'($urandom(32'hcfcb_eda8));
        aclken = 1'b1;
        rst_n = 1'b0;
        start = 1'b0;
        cfg = '0;
        pixels_s_valid = 1'b0;
        pixels_s_data = '0;
        weights_s_valid = 1'b0;
        weights_s_data = '0;
        check_errors = 0;
        other_errors = 0;
        out_cnt = 0;
        done_cnt = 0;
        aborted = 1'b0;
        $readmemh("verif/conv_stimulus.txt", stim);
        repeat (3) @(posedge aclk);
        #2;
        rst_n = 1'b1;
        njobs = int'(stim[0][7:0]);
        ptr = 1;
        for (int j = 0; j < njobs && !aborted; j++) begin
            run_job(j, ptr);
        end
        other_errors += dut0.asserts0.fail_cnt;
        $display("errors: %0d value mismatches, %0d other failures",
                 check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/conv_engine_asserts.sv */
////////////////////
// Bound to axis_conv_engine
////////////////////
`timescale 1ns/1ps
`default_nettype none

module conv_engine_asserts (
    input wire                             aclk,
    input wire                             aclken,
    input wire                             rst_n,
    input wire                             start,
    input wire                             pixels_q_valid,
    input wire conv_stream_pkg::pix_beat_t pixels_q_data,
    input wire                             pixels_q_ready,
    input wire                             weights_q_valid,
    input wire conv_stream_pkg::wgt_beat_t weights_q_data,
    input wire                             weights_q_ready,
    input wire                             win_valid,
    input wire conv_stream_pkg::win_beat_t win_data,
    input wire                             win_ready,
    input wire                             m_valid,
    input wire                             done
);

    logic started;
    int   fail_cnt = 0;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (start && aclken) begin
            started <= 1'b1;
        end
    end

    pix_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        pixels_q_valid && !(pixels_q_ready && aclken) |=>
        pixels_q_valid && $stable(pixels_q_data))
        else begin
            $error("pixel beat dropped or changed before it was accepted");
            fail_cnt++;
        end

    wgt_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        weights_q_valid && !(weights_q_ready && aclken) |=>
        weights_q_valid && $stable(weights_q_data))
        else begin
            $error("weight beat dropped or changed before it was accepted");
            fail_cnt++;
        end

    win_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        win_valid && !(win_ready && aclken) |=>
        win_valid && $stable(win_data))
        else begin
            $error("window beat dropped or changed before it was accepted");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge aclk) !rst_n |=> !m_valid && !done)
        else begin
            $error("m_valid or done high during reset");
            fail_cnt++;
        end

    done_after_start: assert property (@(posedge aclk) disable iff (!rst_n)
        done |-> started)
        else begin
            $error("done without a prior start");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* rtl/axis_conv_engine.sv */
////////////////////
// Output has no ready, hold it off with aclken
// Start is ignored until done
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module axis_conv_engine (
    input  wire                            aclk,
    input  wire                            aclken,
    input  wire                            rst_n,
    input  wire                            start,
    input  wire conv_cfg_pkg::conv_cfg_t   cfg,
    input  wire                            pixels_s_valid,
    input  wire conv_stream_pkg::pix_beat_t pixels_s_data,
    output logic                           pixels_s_ready,
    input  wire                            weights_s_valid,
    input  wire conv_stream_pkg::wgt_beat_t weights_s_data,
    output logic                           weights_s_ready,
    output logic                           m_valid,
    output conv_stream_pkg::out_beat_t     m_data,
    output logic                           done
);

    import conv_cfg_pkg::*;
    import conv_stream_pkg::*;

    pix_beat_t          pixels_q_data;
    logic               pixels_q_valid;
    logic               pixels_q_ready;
    logic               pixels_slice_ready;
    wgt_beat_t          weights_q_data;
    logic               weights_q_valid;
    logic               weights_q_ready;
    logic               weights_slice_ready;
    win_beat_t          win_data;
    logic               win_valid;
    logic               win_ready;
    logic               sb_active;
    logic               conv_valid;
    logic               u_ready [`CONV_UNITS];
    logic               u_valid [`CONV_UNITS];
    logic               u_last  [`CONV_UNITS];
    acc_t               u_data  [`CONV_UNITS];
    conv_cfg_t          cfg_q;
    logic               job_q;
    logic [`COLS_W-1:0] grp_q;

    assign pixels_s_ready  = pixels_slice_ready && sb_active;
    assign weights_s_ready = weights_slice_ready && sb_active;

    axis_reg_slice #(.payload_t(pix_beat_t)) pixels_slice (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
        .s_valid(pixels_s_valid && sb_active), .s_data(pixels_s_data),
        .s_ready(pixels_slice_ready),
        .m_valid(pixels_q_valid), .m_data(pixels_q_data), .m_ready(pixels_q_ready)
    );

    axis_reg_slice #(.payload_t(wgt_beat_t)) weights_slice (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
        .s_valid(weights_s_valid && sb_active), .s_data(weights_s_data),
        .s_ready(weights_slice_ready),
        .m_valid(weights_q_valid), .m_data(weights_q_data), .m_ready(weights_q_ready)
    );

    axis_shift_buffer shift_buffer (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
        .start(start && !job_q), .cfg(cfg), .active(sb_active),
        .s_valid(pixels_q_valid), .s_data(pixels_q_data), .s_ready(pixels_q_ready),
        .m_valid(win_valid), .m_data(win_data), .m_ready(win_ready)
    );

    // Join of window and weight beat, units are identical so unit 0 speaks for all
    assign conv_valid      = win_valid && weights_q_valid;
    assign win_ready       = u_ready[0] && weights_q_valid;
    assign weights_q_ready = u_ready[0] && win_valid;

    for (genvar i = 0; i < `CONV_UNITS; i++) begin : g_unit
        conv_unit unit (
            .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .is_relu(cfg_q.is_relu),
            .s_valid(conv_valid), .s_pixel(win_data.pix[i]), .s_weights(weights_q_data),
            .s_last(win_data.last), .s_user(win_data.user), .s_ready(u_ready[i]),
            .m_valid(u_valid[i]), .m_data(u_data[i]), .m_last(u_last[i])
        );
    end

    assign m_valid = u_valid[0];

    always_comb begin
        m_data.last = u_last[0] && (grp_q == cfg_q.cols_1);
        for (int i = 0; i < `CONV_UNITS; i++) begin
            m_data.res[i] = u_data[i];
        end
    end

    // Output group counter
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cfg_q <= '0;
            job_q <= 1'b0;
            grp_q <= '0;
            done  <= 1'b0;
        end else if (aclken) begin
            done <= 1'b0;
            if (start && !job_q) begin
                cfg_q <= cfg;
                job_q <= 1'b1;
                grp_q <= '0;
            end
            if (u_valid[0]) begin
                if (grp_q == cfg_q.cols_1) begin
                    grp_q <= '0;
                    job_q <= 1'b0;
                    done  <= 1'b1;
                end else begin
                    grp_q <= grp_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/conv_unit.sv */
////////////////////
// Never stalls, s_ready follows aclken
// MULTIPLIER_DELAY must be at least 1
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_unit (
    input  wire                          aclk,
    input  wire                          aclken,
    input  wire                          rst_n,
    input  wire                          is_relu,
    input  wire                          s_valid,
    input  wire signed [`DATA_WIDTH-1:0] s_pixel,
    input  wire conv_stream_pkg::wgt_beat_t s_weights,
    input  wire                          s_last,
    input  wire conv_cfg_pkg::tuser_t    s_user,
    output logic                         s_ready,
    output logic                         m_valid,
    output logic signed [`ACC_WIDTH-1:0] m_data,
    output logic                         m_last
);

    import conv_stream_pkg::*;

    localparam int MD = `MULTIPLIER_DELAY;

    typedef struct packed {
        logic valid;
        logic last;
        logic first;
        logic is_max;
    } stage_t;

    stage_t [MD-1:0]                 st_q;
    acc_t                            val_q [MD];
    data_t                           w_sel;
    logic signed [2*`DATA_WIDTH-1:0] prod;
    acc_t                            val_d;
    acc_t                            val_o;
    stage_t                          st_o;
    acc_t                            acc_q;
    acc_t                            acc_nx;

    assign s_ready = aclken;
    assign w_sel   = s_weights.w[s_user.krow];
    assign prod    = s_pixel * w_sel;
    // Max mode bypasses the product
    assign val_d   = s_user.is_max ? acc_t'(s_pixel) : acc_t'(prod);
    assign val_o   = val_q[MD-1];
    assign st_o    = st_q[MD-1];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            st_q <= '0;
        end else if (aclken) begin
            st_q[0] <= '{valid: s_valid, last: s_last, first: s_user.first,
                         is_max: s_user.is_max};
            for (int k = 1; k < MD; k++) begin
                st_q[k] <= st_q[k-1];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            val_q[0] <= val_d;
            for (int k = 1; k < MD; k++) begin
                val_q[k] <= val_q[k-1];
            end
        end
    end

    always_comb begin
        if (st_o.first) begin
            acc_nx = val_o;
        end else if (st_o.is_max) begin
            acc_nx = (val_o > acc_q) ? val_o : acc_q;
        end else begin
            acc_nx = acc_q + val_o;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end else if (aclken) begin
            m_valid <= st_o.valid && st_o.last;
            m_last  <= st_o.valid && st_o.last;
        end
    end

    // Result is taken from acc_nx so the next group can start at once
    always_ff @(posedge aclk) begin
        if (aclken && st_o.valid) begin
            acc_q <= acc_nx;
            if (st_o.last) begin
                m_data <= (is_relu && acc_nx[`ACC_WIDTH-1]) ? '0 : acc_nx;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/axis_shift_buffer.sv */
////////////////////
// One window per kernel row, input stalls while a beat drains
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module axis_shift_buffer (
    input  wire                         aclk,
    input  wire                         aclken,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire conv_cfg_pkg::conv_cfg_t cfg,
    output logic                        active,
    input  wire                         s_valid,
    input  wire conv_stream_pkg::pix_beat_t s_data,
    output logic                        s_ready,
    output logic                        m_valid,
    output conv_stream_pkg::win_beat_t  m_data,
    input  wire                         m_ready
);

    import conv_cfg_pkg::*;
    import conv_stream_pkg::*;

    conv_cfg_t          cfg_q;
    pix_beat_t          rest_q;
    logic [`KROW_W-1:0] krow_q;
    logic [`KROW_W-1:0] krow_nx;
    logic [`CIN_W-1:0]  cin_q;
    logic [`CIN_W-1:0]  cin_n;
    logic [`COLS_W-1:0] col_q;
    logic [`COLS_W-1:0] col_n;
    logic               beats_done;
    logic               hs;
    logic               row_end;
    logic               load;
    logic               step;
    logic               job_end;

    assign hs      = m_valid && m_ready && aclken;
    assign row_end = (krow_q == cfg_q.kernel_h_1);
    assign krow_nx = krow_q + 1'b1;
    // Next beat may enter on the handshake of the last row
    assign s_ready = active && !beats_done && (!m_valid || (m_ready && row_end));
    assign load    = s_valid && s_ready && aclken;
    assign step    = hs && !row_end;
    assign job_end = hs && row_end && (cin_q == cfg_q.cin_1) && (col_q == cfg_q.cols_1);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cfg_q      <= '0;
            active     <= 1'b0;
            beats_done <= 1'b0;
            m_valid    <= 1'b0;
            krow_q     <= '0;
            cin_q      <= '0;
            col_q      <= '0;
            cin_n      <= '0;
            col_n      <= '0;
        end else if (aclken) begin
            if (start && !active) begin
                cfg_q      <= cfg;
                active     <= 1'b1;
                beats_done <= 1'b0;
                cin_n      <= '0;
                col_n      <= '0;
            end
            if (load) begin
                m_valid <= 1'b1;
                krow_q  <= '0;
                cin_q   <= cin_n;
                col_q   <= col_n;
                if (cin_n == cfg_q.cin_1) begin
                    cin_n      <= '0;
                    col_n      <= col_n + 1'b1;
                    beats_done <= (col_n == cfg_q.cols_1);
                end else begin
                    cin_n <= cin_n + 1'b1;
                end
            end else if (step) begin
                krow_q <= krow_nx;
            end else if (hs) begin
                m_valid <= 1'b0;
            end
            if (job_end) begin
                active <= 1'b0;
            end
        end
    end

    // Unit i sees pixel i+krow, rest_q drops one pixel per row
    always_ff @(posedge aclk) begin
        if (aclken && load) begin
            for (int i = 0; i < `CONV_UNITS; i++) begin
                m_data.pix[i] <= s_data.pix[i];
            end
            rest_q.pix       <= s_data.pix >> `DATA_WIDTH;
            m_data.last      <= (cfg_q.kernel_h_1 == '0) && (cin_n == cfg_q.cin_1);
            m_data.user.krow <= '0;
            m_data.user.first <= (cin_n == '0);
            m_data.user.is_max <= cfg_q.is_max;
        end else if (aclken && step) begin
            for (int i = 0; i < `CONV_UNITS; i++) begin
                m_data.pix[i] <= rest_q.pix[i];
            end
            rest_q.pix        <= rest_q.pix >> `DATA_WIDTH;
            m_data.last       <= (krow_nx == cfg_q.kernel_h_1) && (cin_q == cfg_q.cin_1);
            m_data.user.krow  <= krow_nx;
            m_data.user.first <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/axis_reg_slice.sv */
////////////////////
// Two-entry skid buffer, s_ready comes from a register
////////////////////
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice #(
    parameter type payload_t = logic
) (
    input  wire           aclk,
    input  wire           aclken,
    input  wire           rst_n,
    input  wire           s_valid,
    input  wire payload_t s_data,
    output logic          s_ready,
    output logic          m_valid,
    output payload_t      m_data,
    input  wire           m_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     push;
    logic     drain;

    assign s_ready = !skid_valid;
    assign push    = s_valid && s_ready;
    assign drain   = !m_valid || m_ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (aclken) begin
            if (drain) begin
                m_valid    <= skid_valid || push;
                skid_valid <= 1'b0;
            end else if (push) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // Skid entry drains first to keep beat order
    always_ff @(posedge aclk) begin
        if (aclken) begin
            if (drain) begin
                m_data <= skid_valid ? skid_data : s_data;
            end else if (push) begin
                skid_data <= s_data;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/conv_stream_pkg.sv */
////////////////////
// Beat layouts of the pixel, weight, window and output streams
////////////////////
`default_nettype none

`include "conv_defines.svh"

package conv_stream_pkg;

    // Unit rows plus the halo rows
    localparam int PIX_N = `CONV_UNITS + `KERNEL_H_MAX - 1;

    typedef logic signed [`DATA_WIDTH-1:0] data_t;
    typedef logic signed [`ACC_WIDTH-1:0]  acc_t;

    typedef struct packed {
        data_t [PIX_N-1:0] pix;
    } pix_beat_t;

    // One weight per kernel row, same channel
    typedef struct packed {
        data_t [`KERNEL_H_MAX-1:0] w;
    } wgt_beat_t;

    typedef struct packed {
        data_t [`CONV_UNITS-1:0] pix;
        logic                    last;
        conv_cfg_pkg::tuser_t    user;
    } win_beat_t;

    typedef struct packed {
        acc_t [`CONV_UNITS-1:0] res;
        logic                   last;
    } out_beat_t;

endpackage

`default_nettype wire

/* rtl/conv_cfg_pkg.sv */
////////////////////
// Job configuration and window side info
////////////////////
`default_nettype none

`include "conv_defines.svh"

package conv_cfg_pkg;

    typedef struct packed {
        logic [`KROW_W-1:0] kernel_h_1;
        logic               is_max;
        logic               is_relu;
        logic [`COLS_W-1:0] cols_1;
        logic [`CIN_W-1:0]  cin_1;
    } conv_cfg_t;

    typedef struct packed {
        logic [`KROW_W-1:0] krow;
        logic               first;
        logic               is_max;
    } tuser_t;

endpackage

`default_nettype wire

/* rtl/conv_defines.svh */
////////////////////
// Sizes of the core, KERNEL_H_MAX must be odd
// ACC_WIDTH can overflow on large channel counts
////////////////////
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

`define CONV_UNITS       4
`define DATA_WIDTH       8
`define KERNEL_H_MAX     3
`define ACC_WIDTH        20
`define MULTIPLIER_DELAY 2

// Counter widths
`define KROW_W           2
`define CIN_W            4
`define COLS_W           4

`endif
